// ==== lab4_reg_pkg.sv ====
package lab4_reg_pkg;

	//////////////////////////////////////////////////
	// bus types
	//////////////////////////////////////////////////

	typedef logic [6:0]  wb_adr_t;
	typedef logic [31:0] wb_data_t;

	// one bus cycle as seen by the slave
	typedef struct packed {
		logic     cyc;
		logic     stb;
		logic     we;
		wb_adr_t  adr;
		wb_data_t dat;
	} wb_req_t;

	//////////////////////////////////////////////////
	// register map
	//////////////////////////////////////////////////

	localparam wb_adr_t ADR_CONTROL        = 7'h00;
	localparam wb_adr_t ADR_SHIFT_PRESCALE = 7'h04;
	localparam wb_adr_t ADR_RAMP_TO_WILK   = 7'h0C;
	localparam wb_adr_t ADR_WCLK_STOP      = 7'h10;
	localparam wb_adr_t ADR_SERIAL_WRITE   = 7'h18;

	// control register fields
	localparam int unsigned CTRL_RESET_REQ    = 0;
	localparam int unsigned CTRL_RUNMODE      = 1;
	localparam int unsigned CTRL_RAMP_PENDING = 3;
	localparam int unsigned CTRL_WILK_RESET   = 8;
	localparam int unsigned CTRL_RAMP_START   = 9;
	localparam int unsigned CTRL_REGCLR_LSB   = 16;

	// serial write register fields
	localparam int unsigned SER_WORD_LSB = 0;
	localparam int unsigned SER_SEL_LSB  = 24;
	localparam int unsigned SER_REQ      = 31;

	// reset values
	localparam logic [7:0]  PRESCALE_DEFAULT     = 8'h00;
	localparam logic [15:0] RAMP_TO_WILK_DEFAULT = 16'h0000;
	localparam logic [15:0] WCLK_STOP_DEFAULT    = 16'd1024;

endpackage

// ==== lab4_chip_pkg.sv ====
package lab4_chip_pkg;

	//////////////////////////////////////////////////
	// chip-side widths
	//////////////////////////////////////////////////

	// length of one LAB4 configuration word
	localparam int unsigned SERIAL_BITS = 24;

	typedef logic [SERIAL_BITS-1:0] serial_word_t;
	// values past the last chip select every chip
	typedef logic [3:0]             chip_sel_t;
	typedef logic [7:0]             prescale_t;
	typedef logic [15:0]            wilk_count_t;

	//////////////////////////////////////////////////
	// commands from the register stage
	//////////////////////////////////////////////////

	typedef struct packed {
		serial_word_t word;
		chip_sel_t    sel;
	} serial_cmd_t;

	typedef struct packed {
		wilk_count_t ramp_to_wilk;
		wilk_count_t wclk_stop;
	} ramp_cfg_t;

endpackage

// ==== lab4_reg_bank.sv ====
`timescale 1ns/1ps

module lab4_reg_bank #(
	parameter int unsigned NUM_CHIPS = 12
) (
	input  logic                        clk_i,
	input  logic                        rst_n_i,
	input  lab4_reg_pkg::wb_req_t       bus_i,
	output lab4_reg_pkg::wb_data_t      dat_o,
	output logic                        ack_o,
	output lab4_chip_pkg::serial_cmd_t  cmd_o,
	output logic                        launch_o,
	input  logic                        busy_i,
	output lab4_chip_pkg::prescale_t    prescale_o,
	output lab4_chip_pkg::ramp_cfg_t    cfg_o,
	output logic                        ramp_start_o,
	output logic                        wilk_reset_o,
	input  logic                        ramp_busy_i,
	output logic [NUM_CHIPS-1:0]        regclr_o
);
	import lab4_reg_pkg::*;
	import lab4_chip_pkg::*;

	logic                 ack_q;
	logic                 bus_req;
	logic                 wr_en;
	logic                 launch;
	logic                 reset_req_q;
	logic                 runmode_q;
	logic [NUM_CHIPS-1:0] regclr_q;
	prescale_t            prescale_q;
	ramp_cfg_t            cfg_q;
	serial_cmd_t          cmd_q;
	logic                 pending_q;
	logic                 ramp_start_q;
	logic                 wilk_reset_q;
	wb_data_t             rd_data;
	wb_data_t             dat_q;

	// ack is never high two cycles running
	assign bus_req = bus_i.cyc && bus_i.stb && !ack_q;
	assign wr_en   = bus_req && bus_i.we;

	// hand the held request over only when the shifter is free
	assign launch = pending_q && !busy_i;

	//////////////////////////////////////////////////
	// register writes
	//////////////////////////////////////////////////

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ack_q              <= 1'b0;
			reset_req_q        <= 1'b0;
			runmode_q          <= 1'b0;
			regclr_q           <= '0;
			prescale_q         <= PRESCALE_DEFAULT;
			cfg_q.ramp_to_wilk <= RAMP_TO_WILK_DEFAULT;
			cfg_q.wclk_stop    <= WCLK_STOP_DEFAULT;
			cmd_q              <= '0;
			pending_q          <= 1'b0;
			ramp_start_q       <= 1'b0;
			wilk_reset_q       <= 1'b0;
		end else begin
			ack_q        <= bus_req;
			ramp_start_q <= 1'b0;
			wilk_reset_q <= 1'b0;

			if (launch) begin
				pending_q <= 1'b0;
			end

			if (wr_en) begin
				case (bus_i.adr)
					ADR_CONTROL: begin
						reset_req_q  <= bus_i.dat[CTRL_RESET_REQ];
						runmode_q    <= bus_i.dat[CTRL_RUNMODE];
						regclr_q     <= bus_i.dat[CTRL_REGCLR_LSB +: NUM_CHIPS];
						wilk_reset_q <= bus_i.dat[CTRL_WILK_RESET];
						ramp_start_q <= bus_i.dat[CTRL_RAMP_START];
					end
					ADR_SHIFT_PRESCALE: begin
						prescale_q <= bus_i.dat[$bits(prescale_t)-1:0];
					end
					ADR_RAMP_TO_WILK: begin
						cfg_q.ramp_to_wilk <= bus_i.dat[$bits(wilk_count_t)-1:0];
					end
					ADR_WCLK_STOP: begin
						cfg_q.wclk_stop <= bus_i.dat[$bits(wilk_count_t)-1:0];
					end
					ADR_SERIAL_WRITE: begin
						cmd_q.word <= bus_i.dat[SER_WORD_LSB +: $bits(serial_word_t)];
						cmd_q.sel  <= bus_i.dat[SER_SEL_LSB +: $bits(chip_sel_t)];
						// a new write wins over the launch clear
						pending_q  <= bus_i.dat[SER_REQ];
					end
					default: begin
					end
				endcase
			end
		end
	end

	//////////////////////////////////////////////////
	// read back
	//////////////////////////////////////////////////

	// pulse bits always read as zero
	always_comb begin
		rd_data = '0;
		case (bus_i.adr)
			ADR_CONTROL: begin
				rd_data[CTRL_RESET_REQ]               = reset_req_q;
				rd_data[CTRL_RUNMODE]                 = runmode_q;
				rd_data[CTRL_RAMP_PENDING]            = ramp_busy_i;
				rd_data[CTRL_REGCLR_LSB +: NUM_CHIPS] = regclr_q;
			end
			ADR_SHIFT_PRESCALE: begin
				rd_data[$bits(prescale_t)-1:0] = prescale_q;
			end
			ADR_RAMP_TO_WILK: begin
				rd_data[$bits(wilk_count_t)-1:0] = cfg_q.ramp_to_wilk;
			end
			ADR_WCLK_STOP: begin
				rd_data[$bits(wilk_count_t)-1:0] = cfg_q.wclk_stop;
			end
			ADR_SERIAL_WRITE: begin
				rd_data[SER_WORD_LSB +: $bits(serial_word_t)] = cmd_q.word;
				rd_data[SER_SEL_LSB +: $bits(chip_sel_t)]     = cmd_q.sel;
				rd_data[SER_REQ]                              = pending_q;
			end
			default: begin
			end
		endcase
	end

	// captured with the ack so it is valid during the ack cycle
	always_ff @(posedge clk_i) begin
		if (bus_req) begin
			dat_q <= rd_data;
		end
	end

	assign dat_o        = dat_q;
	assign ack_o        = ack_q;
	assign cmd_o        = cmd_q;
	assign launch_o     = launch;
	assign prescale_o   = prescale_q;
	assign cfg_o        = cfg_q;
	assign ramp_start_o = ramp_start_q;
	assign wilk_reset_o = wilk_reset_q;
	assign regclr_o     = regclr_q;

endmodule

// ==== lab4_serial_shifter.sv ====
`timescale 1ns/1ps

module lab4_serial_shifter #(
	parameter int unsigned NUM_CHIPS = 12
) (
	input  logic                        clk_i,
	input  logic                        rst_n_i,
	input  lab4_chip_pkg::serial_cmd_t  cmd_i,
	input  logic                        launch_i,
	input  lab4_chip_pkg::prescale_t    prescale_i,
	output logic                        busy_o,
	output logic [NUM_CHIPS-1:0]        sin_o,
	output logic [NUM_CHIPS-1:0]        sclk_o,
	output logic [NUM_CHIPS-1:0]        pclk_o
);
	import lab4_chip_pkg::*;

	localparam int unsigned          BIT_CNT_W = $clog2(SERIAL_BITS);
	localparam logic [BIT_CNT_W-1:0] BIT_LAST  = BIT_CNT_W'(SERIAL_BITS - 1);
	localparam chip_sel_t            SEL_LAST  = chip_sel_t'(NUM_CHIPS - 1);

	typedef enum logic [1:0] {
		SHIFT_IDLE,
		SHIFT_DATA,
		SHIFT_LATCH
	} shift_state_t;

	shift_state_t         state_q;
	serial_word_t         word_q;
	chip_sel_t            sel_q;
	prescale_t            presc_q;
	prescale_t            tick_q;
	logic                 half_q;
	logic [BIT_CNT_W-1:0] bit_q;
	logic                 half_end;
	logic                 start;
	logic                 sin_line;
	logic                 sclk_line;
	logic                 pclk_line;
	logic [NUM_CHIPS-1:0] chip_en;

	// each half of a bit or of the latch lasts prescale+1 cycles
	assign half_end = (tick_q == presc_q);
	assign start    = (state_q == SHIFT_IDLE) && launch_i;

	//////////////////////////////////////////////////
	// sequencing
	//////////////////////////////////////////////////

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= SHIFT_IDLE;
			tick_q  <= '0;
			half_q  <= 1'b0;
			bit_q   <= '0;
		end else begin
			if (state_q != SHIFT_IDLE) begin
				if (half_end) begin
					tick_q <= '0;
					half_q <= !half_q;
				end else begin
					tick_q <= tick_q + 1'b1;
				end
			end

			case (state_q)
				SHIFT_IDLE: begin
					if (launch_i) begin
						state_q <= SHIFT_DATA;
						tick_q  <= '0;
						half_q  <= 1'b0;
						bit_q   <= BIT_LAST;
					end
				end
				SHIFT_DATA: begin
					// bit ends after its sclk high half
					if (half_end && half_q) begin
						if (bit_q == '0) begin
							state_q <= SHIFT_LATCH;
						end else begin
							bit_q <= bit_q - 1'b1;
						end
					end
				end
				SHIFT_LATCH: begin
					if (half_end && half_q) begin
						state_q <= SHIFT_IDLE;
					end
				end
				default: begin
					state_q <= SHIFT_IDLE;
				end
			endcase
		end
	end

	// word, select and prescale held for the whole transfer
	always_ff @(posedge clk_i) begin
		if (start) begin
			word_q  <= cmd_i.word;
			sel_q   <= cmd_i.sel;
			presc_q <= prescale_i;
		end else if (state_q == SHIFT_DATA && half_end && half_q) begin
			word_q <= {word_q[SERIAL_BITS-2:0], 1'b0};
		end
	end

	//////////////////////////////////////////////////
	// chip lines
	//////////////////////////////////////////////////

	// msb first, sclk low then high
	assign sin_line  = (state_q == SHIFT_DATA) && word_q[SERIAL_BITS-1];
	assign sclk_line = (state_q == SHIFT_DATA) && half_q;
	// pclk high in the first latch half only
	assign pclk_line = (state_q == SHIFT_LATCH) && !half_q;

	always_comb begin
		for (int i = 0; i < NUM_CHIPS; i++) begin
			chip_en[i] = (sel_q > SEL_LAST) || (sel_q == chip_sel_t'(i));
		end
	end

	assign busy_o = (state_q != SHIFT_IDLE);
	assign sin_o  = chip_en & {NUM_CHIPS{sin_line}};
	assign sclk_o = chip_en & {NUM_CHIPS{sclk_line}};
	assign pclk_o = chip_en & {NUM_CHIPS{pclk_line}};

endmodule

// ==== lab4_ramp_sequencer.sv ====
`timescale 1ns/1ps

module lab4_ramp_sequencer (
	input  logic                      clk_i,
	input  logic                      rst_n_i,
	input  lab4_chip_pkg::ramp_cfg_t  cfg_i,
	input  logic                      start_i,
	input  logic                      wilk_reset_i,
	output logic                      busy_o,
	output logic                      ramp_o,
	output logic                      wclk_o
);
	import lab4_chip_pkg::*;

	// wide enough for twice the wclk count
	localparam int unsigned CNT_W = $bits(wilk_count_t) + 1;

	typedef enum logic [1:0] {
		RAMP_IDLE,
		RAMP_DELAY,
		RAMP_RUN
	} ramp_state_t;

	ramp_state_t      state_q;
	logic [CNT_W-1:0] cnt_q;
	wilk_count_t      wclk_stop_q;
	logic             wclk_q;

	// two toggles per wclk period, counted down to zero
	function automatic logic [CNT_W-1:0] run_load(input wilk_count_t n);
		return {n, 1'b0} - 1'b1;
	endfunction

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q     <= RAMP_IDLE;
			cnt_q       <= '0;
			wclk_stop_q <= '0;
			wclk_q      <= 1'b0;
		end else if (wilk_reset_i) begin
			// abort wins over everything else
			state_q <= RAMP_IDLE;
			cnt_q   <= '0;
			wclk_q  <= 1'b0;
		end else begin
			case (state_q)
				RAMP_IDLE: begin
					if (start_i) begin
						wclk_stop_q <= cfg_i.wclk_stop;
						if (cfg_i.ramp_to_wilk != '0) begin
							state_q <= RAMP_DELAY;
							cnt_q   <= {1'b0, cfg_i.ramp_to_wilk} - 1'b1;
						end else if (cfg_i.wclk_stop != '0) begin
							state_q <= RAMP_RUN;
							cnt_q   <= run_load(cfg_i.wclk_stop);
							wclk_q  <= 1'b1;
						end
					end
				end
				RAMP_DELAY: begin
					if (cnt_q == '0) begin
						if (wclk_stop_q != '0) begin
							state_q <= RAMP_RUN;
							cnt_q   <= run_load(wclk_stop_q);
							wclk_q  <= 1'b1;
						end else begin
							state_q <= RAMP_IDLE;
						end
					end else begin
						cnt_q <= cnt_q - 1'b1;
					end
				end
				RAMP_RUN: begin
					if (cnt_q == '0) begin
						state_q <= RAMP_IDLE;
						wclk_q  <= 1'b0;
					end else begin
						cnt_q  <= cnt_q - 1'b1;
						wclk_q <= !wclk_q;
					end
				end
				default: begin
					state_q <= RAMP_IDLE;
				end
			endcase
		end
	end

	// ramp stays up through delay and wclk run
	assign busy_o = (state_q != RAMP_IDLE);
	assign ramp_o = (state_q != RAMP_IDLE);
	assign wclk_o = wclk_q;

endmodule

// ==== lab4_controller.sv ====
`timescale 1ns/1ps

module lab4_controller #(
	parameter int unsigned NUM_CHIPS = 12
) (
	input  logic                    clk_i,
	input  logic                    rst_n_i,
	input  lab4_reg_pkg::wb_req_t   bus_i,
	output lab4_reg_pkg::wb_data_t  dat_o,
	output logic                    ack_o,
	output logic [NUM_CHIPS-1:0]    sin_o,
	output logic [NUM_CHIPS-1:0]    sclk_o,
	output logic [NUM_CHIPS-1:0]    pclk_o,
	output logic [NUM_CHIPS-1:0]    regclr_o,
	output logic [NUM_CHIPS-1:0]    ramp_o,
	output logic [NUM_CHIPS-1:0]    wclk_p_o,
	output logic [NUM_CHIPS-1:0]    wclk_n_o
);
	import lab4_chip_pkg::*;

	serial_cmd_t serial_cmd;
	logic        serial_launch;
	logic        serial_busy;
	prescale_t   shift_prescale;
	ramp_cfg_t   ramp_cfg;
	logic        ramp_start;
	logic        wilk_reset;
	logic        ramp_busy;
	logic        ramp_line;
	logic        wclk_line;

	//////////////////////////////////////////////////
	// register stage
	//////////////////////////////////////////////////

	lab4_reg_bank #(
		.NUM_CHIPS(NUM_CHIPS)
	) u_reg_bank (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.bus_i        (bus_i),
		.dat_o        (dat_o),
		.ack_o        (ack_o),
		.cmd_o        (serial_cmd),
		.launch_o     (serial_launch),
		.busy_i       (serial_busy),
		.prescale_o   (shift_prescale),
		.cfg_o        (ramp_cfg),
		.ramp_start_o (ramp_start),
		.wilk_reset_o (wilk_reset),
		.ramp_busy_i  (ramp_busy),
		.regclr_o     (regclr_o)
	);

	//////////////////////////////////////////////////
	// chip stage
	//////////////////////////////////////////////////

	lab4_serial_shifter #(
		.NUM_CHIPS(NUM_CHIPS)
	) u_shifter (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.cmd_i      (serial_cmd),
		.launch_i   (serial_launch),
		.prescale_i (shift_prescale),
		.busy_o     (serial_busy),
		.sin_o      (sin_o),
		.sclk_o     (sclk_o),
		.pclk_o     (pclk_o)
	);

	lab4_ramp_sequencer u_ramp (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.cfg_i        (ramp_cfg),
		.start_i      (ramp_start),
		.wilk_reset_i (wilk_reset),
		.busy_o       (ramp_busy),
		.ramp_o       (ramp_line),
		.wclk_o       (wclk_line)
	);

	// ramp and wclk are common to every chip
	assign ramp_o   = {NUM_CHIPS{ramp_line}};
	assign wclk_p_o = {NUM_CHIPS{wclk_line}};
	assign wclk_n_o = {NUM_CHIPS{!wclk_line}};

endmodule

// ==== tb_lab4_controller.sv ====
`timescale 1ns/1ps

module tb_lab4_controller;
	import lab4_reg_pkg::*;
	import lab4_chip_pkg::*;

	localparam int unsigned NUM_CHIPS    = 12;
	localparam int unsigned DRIVE_DELAY  = 10;
	localparam int unsigned ACK_LIMIT    = 20;
	localparam int unsigned SERIAL_LIMIT = 300;
	localparam int unsigned RAMP_LIMIT   = 200;
	// stored control bits are reset request, runmode and regclear
	localparam wb_data_t CTRL_MASK = 32'h3 | (((32'd1 << NUM_CHIPS) - 1) << CTRL_REGCLR_LSB);

	typedef struct packed {
		serial_word_t word;
		chip_sel_t    sel;
		prescale_t    presc;
	} serial_expect_t;

	logic                 clk_i;
	logic                 rst_n_i;
	wb_req_t              bus_i;
	wb_data_t             dat_o;
	logic                 ack_o;
	logic [NUM_CHIPS-1:0] sin_o;
	logic [NUM_CHIPS-1:0] sclk_o;
	logic [NUM_CHIPS-1:0] pclk_o;
	logic [NUM_CHIPS-1:0] regclr_o;
	logic [NUM_CHIPS-1:0] ramp_o;
	logic [NUM_CHIPS-1:0] wclk_p_o;
	logic [NUM_CHIPS-1:0] wclk_n_o;
	logic [NUM_CHIPS-1:0] wclk_inv;

	// reference model state
	logic [15:0]          lfsr_state;
	wb_data_t             exp_ctrl;
	wb_data_t             exp_presc;
	wb_data_t             exp_r2w;
	wb_data_t             exp_wstop;
	serial_expect_t       serial_q[$];
	serial_expect_t       done_cmd;
	serial_word_t         cap_word [NUM_CHIPS];
	int unsigned          cap_bits [NUM_CHIPS];
	int unsigned          pclk_cnt [NUM_CHIPS];
	logic [NUM_CHIPS-1:0] sclk_prev;
	logic [NUM_CHIPS-1:0] pclk_prev;
	logic [NUM_CHIPS-1:0] active_mask;
	logic                 busy_prev;
	int unsigned          busy_len;
	int unsigned          delivered;
	logic                 ramp_prev;
	logic                 wclk_prev;
	logic                 ack_prev;
	int unsigned          ramp_len;
	int unsigned          wclk_rises;
	int unsigned          first_rise;
	int unsigned          last_len;
	int unsigned          last_rises;
	int unsigned          last_first;
	int unsigned          ramp_runs;

	lab4_controller #(
		.NUM_CHIPS(NUM_CHIPS)
	) uut (
		.clk_i    (clk_i),
		.rst_n_i  (rst_n_i),
		.bus_i    (bus_i),
		.dat_o    (dat_o),
		.ack_o    (ack_o),
		.sin_o    (sin_o),
		.sclk_o   (sclk_o),
		.pclk_o   (pclk_o),
		.regclr_o (regclr_o),
		.ramp_o   (ramp_o),
		.wclk_p_o (wclk_p_o),
		.wclk_n_o (wclk_n_o)
	);

	assign wclk_inv = ~wclk_p_o;

	initial clk_i = 1'b0;
	always #50 clk_i = !clk_i;

	//////////////////////////////////////////////////
	// random numbers and error handling
	//////////////////////////////////////////////////

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// one lfsr step per bit taken
	function automatic logic [31:0] random_bits(input int unsigned n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	task automatic halt_run();
		$display("*** TEST FAILED ***");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic report_failure(input string msg);
		$display("ERROR at %0t ns: %s", $time, msg);
		halt_run();
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("MISMATCH at %0t ns: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
			halt_run();
		end
	endtask

	// select values past the last chip address every chip
	function automatic logic chip_selected(input chip_sel_t sel, input int unsigned i);
		return (32'(sel) >= NUM_CHIPS) || (32'(sel) == i);
	endfunction

	//////////////////////////////////////////////////
	// bus access
	//////////////////////////////////////////////////

	task automatic access_reg(input logic we, input wb_adr_t adr, input wb_data_t wdata,
			output wb_data_t rdata);
		int unsigned cycles;
		@(posedge clk_i);
		#(DRIVE_DELAY);
		bus_i.cyc = 1'b1;
		bus_i.stb = 1'b1;
		bus_i.we  = we;
		bus_i.adr = adr;
		bus_i.dat = wdata;
		cycles = 0;
		do begin
			@(negedge clk_i);
			cycles++;
		end while (!ack_o && cycles < ACK_LIMIT);
		if (!ack_o) begin
			report_failure($sformatf("no ack for address 0x%02h", adr));
		end
		rdata = dat_o;
		@(posedge clk_i);
		#(DRIVE_DELAY);
		bus_i = '0;
	endtask

	task automatic write_reg(input wb_adr_t adr, input wb_data_t data);
		wb_data_t unused;
		access_reg(1'b1, adr, data, unused);
	endtask

	task automatic read_check(input wb_adr_t adr, input wb_data_t exp, input string name);
		wb_data_t data;
		access_reg(1'b0, adr, '0, data);
		check_value(name, data, exp);
	endtask

	task automatic compare_config();
		read_check(ADR_CONTROL, exp_ctrl, "control register");
		read_check(ADR_SHIFT_PRESCALE, exp_presc, "shift prescale register");
		read_check(ADR_RAMP_TO_WILK, exp_r2w, "ramp to wilk register");
		read_check(ADR_WCLK_STOP, exp_wstop, "wclk stop register");
		check_value("regclr_o", 32'(regclr_o),
			32'(exp_ctrl[CTRL_REGCLR_LSB +: NUM_CHIPS]));
	endtask

	//////////////////////////////////////////////////
	// serial monitor
	//////////////////////////////////////////////////

	task clear_captures();
		for (int i = 0; i < NUM_CHIPS; i++) begin
			cap_word[i] = '0;
			cap_bits[i] = 0;
			pclk_cnt[i] = 0;
		end
		busy_len = 0;
	endtask

	always @(negedge clk_i) begin
		if (!rst_n_i) begin
			clear_captures();
			sclk_prev = '0;
			pclk_prev = '0;
			busy_prev = 1'b0;
			delivered = 0;
		end else begin
			// only the chips of the word in flight may see activity
			active_mask = '0;
			if (uut.serial_busy && serial_q.size() != 0) begin
				for (int i = 0; i < NUM_CHIPS; i++) begin
					active_mask[i] = chip_selected(serial_q[0].sel, i);
				end
			end
			check_value("serial lines of unselected chips",
				32'((sin_o | sclk_o | pclk_o) & ~active_mask), 0);
			for (int i = 0; i < NUM_CHIPS; i++) begin
				// sin is sampled on the sclk rising edge
				if (sclk_o[i] && !sclk_prev[i]) begin
					cap_word[i] = {cap_word[i][SERIAL_BITS-2:0], sin_o[i]};
					cap_bits[i] = cap_bits[i] + 1;
				end
				if (pclk_o[i] && !pclk_prev[i]) begin
					pclk_cnt[i] = pclk_cnt[i] + 1;
				end
			end
			if (uut.serial_busy) begin
				busy_len = busy_len + 1;
			end else if (busy_prev) begin
				if (serial_q.size() == 0) begin
					report_failure("serial transfer ended with no command queued");
				end else begin
					done_cmd = serial_q.pop_front();
					check_value("serial busy cycles", busy_len, 50 * (done_cmd.presc + 1));
					for (int i = 0; i < NUM_CHIPS; i++) begin
						if (chip_selected(done_cmd.sel, i)) begin
							check_value($sformatf("sclk bits chip %0d", i), cap_bits[i], 24);
							check_value($sformatf("word chip %0d", i), 32'(cap_word[i]),
								32'(done_cmd.word));
							check_value($sformatf("pclk pulses chip %0d", i), pclk_cnt[i], 1);
						end else begin
							check_value($sformatf("sclk bits chip %0d", i), cap_bits[i], 0);
							check_value($sformatf("pclk pulses chip %0d", i), pclk_cnt[i], 0);
						end
					end
					clear_captures();
					delivered = delivered + 1;
				end
			end
			sclk_prev = sclk_o;
			pclk_prev = pclk_o;
			busy_prev = uut.serial_busy;
		end
	end

	//////////////////////////////////////////////////
	// ramp and ack monitor
	//////////////////////////////////////////////////

	always @(negedge clk_i) begin
		if (!rst_n_i) begin
			ramp_prev  = 1'b0;
			wclk_prev  = 1'b0;
			ack_prev   = 1'b0;
			ramp_len   = 0;
			wclk_rises = 0;
			first_rise = 0;
			ramp_runs  = 0;
		end else begin
			check_value("wclk_n_o", 32'(wclk_n_o), 32'(wclk_inv));
			check_value("ramp_o", 32'(ramp_o), 32'({NUM_CHIPS{ramp_o[0]}}));
			check_value("wclk_p_o", 32'(wclk_p_o), 32'({NUM_CHIPS{wclk_p_o[0]}}));
			check_value("ack_o twice in a row", 32'(ack_o && ack_prev), 0);
			check_value("wclk_p_o without ramp", 32'(wclk_p_o[0] && !ramp_o[0]), 0);
			if (ramp_o[0]) begin
				ramp_len = ramp_len + 1;
				if (wclk_p_o[0] && !wclk_prev) begin
					if (wclk_rises == 0) begin
						first_rise = ramp_len - 1;
					end
					wclk_rises = wclk_rises + 1;
				end
			end else if (ramp_prev) begin
				last_len   = ramp_len;
				last_rises = wclk_rises;
				last_first = first_rise;
				ramp_runs  = ramp_runs + 1;
				ramp_len   = 0;
				wclk_rises = 0;
				first_rise = 0;
			end
			ramp_prev = ramp_o[0];
			wclk_prev = wclk_p_o[0];
			ack_prev  = ack_o;
		end
	end

	//////////////////////////////////////////////////
	// waits
	//////////////////////////////////////////////////

	task automatic wait_delivered(input int unsigned target);
		int unsigned cycles;
		cycles = 0;
		while (delivered < target && cycles < SERIAL_LIMIT) begin
			@(posedge clk_i);
			cycles++;
		end
		if (delivered < target) begin
			report_failure("timeout waiting for a serial transfer to finish");
		end
	endtask

	task automatic wait_ramp_end(input int unsigned base);
		int unsigned cycles;
		cycles = 0;
		while (ramp_runs == base && cycles < RAMP_LIMIT) begin
			@(posedge clk_i);
			cycles++;
		end
		if (ramp_runs == base) begin
			report_failure("timeout waiting for the ramp to end");
		end
	endtask

	//////////////////////////////////////////////////
	// test sequences
	//////////////////////////////////////////////////

	task automatic check_reset();
		@(negedge clk_i);
		check_value("ack_o", 32'(ack_o), 0);
		check_value("sin_o", 32'(sin_o), 0);
		check_value("sclk_o", 32'(sclk_o), 0);
		check_value("pclk_o", 32'(pclk_o), 0);
		check_value("regclr_o", 32'(regclr_o), 0);
		check_value("ramp_o", 32'(ramp_o), 0);
		check_value("wclk_p_o", 32'(wclk_p_o), 0);
		check_value("wclk_n_o", 32'(wclk_n_o), 32'({NUM_CHIPS{1'b1}}));
		exp_ctrl  = '0;
		exp_presc = '0;
		exp_r2w   = '0;
		exp_wstop = 32'd1024;
		compare_config();
		read_check(ADR_SERIAL_WRITE, '0, "serial write register");
	endtask

	task automatic readback_regs();
		logic [1:0] which;
		wb_data_t   data;
		wb_adr_t    adr;
		repeat (12) begin
			which = 2'(random_bits(2));
			data  = random_bits(32);
			case (which)
				2'd0: begin
					// no ramp start here
					data[CTRL_RAMP_START] = 1'b0;
					write_reg(ADR_CONTROL, data);
					exp_ctrl = data & CTRL_MASK;
				end
				2'd1: begin
					write_reg(ADR_SHIFT_PRESCALE, data);
					exp_presc = data & 32'hFF;
				end
				2'd2: begin
					write_reg(ADR_RAMP_TO_WILK, data);
					exp_r2w = data & 32'hFFFF;
				end
				default: begin
					write_reg(ADR_WCLK_STOP, data);
					exp_wstop = data & 32'hFFFF;
				end
			endcase
			compare_config();
		end
		// everything at 0x40 and above is unmapped
		repeat (6) begin
			adr = wb_adr_t'(random_bits(7)) | 7'h40;
			write_reg(adr, random_bits(32));
			read_check(adr, '0, $sformatf("unmapped address 0x%02h", adr));
		end
		compare_config();
	endtask

	task automatic send_serial(input serial_word_t word, input chip_sel_t sel);
		serial_q.push_back({word, sel, exp_presc[7:0]});
		write_reg(ADR_SERIAL_WRITE, {1'b1, 3'b000, sel, word});
	endtask

	task automatic deliver_words();
		serial_word_t word;
		chip_sel_t    sel;
		int unsigned  target;
		repeat (6) begin
			exp_presc = random_bits(2);
			write_reg(ADR_SHIFT_PRESCALE, exp_presc);
			word   = serial_word_t'(random_bits(24));
			sel    = chip_sel_t'(random_bits(4));
			target = delivered + 1;
			send_serial(word, sel);
			wait_delivered(target);
			read_check(ADR_SERIAL_WRITE, {1'b0, 3'b000, sel, word}, "serial write register");
		end
	endtask

	task automatic back_to_back();
		serial_word_t word_b;
		chip_sel_t    sel_b;
		int unsigned  target;
		exp_presc = random_bits(2);
		write_reg(ADR_SHIFT_PRESCALE, exp_presc);
		target = delivered + 2;
		send_serial(serial_word_t'(random_bits(24)), chip_sel_t'(random_bits(4)));
		word_b = serial_word_t'(random_bits(24));
		sel_b  = chip_sel_t'(random_bits(4));
		send_serial(word_b, sel_b);
		read_check(ADR_SERIAL_WRITE, {1'b1, 3'b000, sel_b, word_b}, "serial pending");
		wait_delivered(target - 1);
		read_check(ADR_SERIAL_WRITE, {1'b0, 3'b000, sel_b, word_b}, "serial after launch");
		wait_delivered(target);
	endtask

	task automatic program_ramp(input int unsigned d, input int unsigned n);
		exp_r2w   = d;
		exp_wstop = n;
		write_reg(ADR_RAMP_TO_WILK, exp_r2w);
		write_reg(ADR_WCLK_STOP, exp_wstop);
		write_reg(ADR_CONTROL, exp_ctrl | (32'd1 << CTRL_RAMP_START));
		read_check(ADR_CONTROL, exp_ctrl | (32'd1 << CTRL_RAMP_PENDING), "ramp pending");
	endtask

	task automatic run_full_ramp(input int unsigned d, input int unsigned n);
		int unsigned base;
		base = ramp_runs;
		program_ramp(d, n);
		wait_ramp_end(base);
		check_value("ramp high cycles", last_len, d + 2 * n);
		check_value("wclk_p rising edges", last_rises, n);
		check_value("ramp to first wclk_p rise", last_first, d);
		read_check(ADR_CONTROL, exp_ctrl, "control after ramp");
	endtask

	task automatic ramp_sequences();
		repeat (4) begin
			run_full_ramp(random_bits(3), 2 + random_bits(3));
		end
	endtask

	task automatic wilk_abort();
		// short delay so the abort lands in the wclk run
		program_ramp(2 + random_bits(2), 16 + random_bits(3));
		write_reg(ADR_CONTROL, exp_ctrl | (32'd1 << CTRL_WILK_RESET));
		@(negedge clk_i);
		check_value("ramp_o after wilk reset", 32'(ramp_o), 0);
		check_value("wclk_p_o after wilk reset", 32'(wclk_p_o), 0);
		read_check(ADR_CONTROL, exp_ctrl, "control after wilk reset");
		run_full_ramp(random_bits(3), 2 + random_bits(3));
	endtask

	initial begin
		lfsr_state = 16'd80;
		rst_n_i    = 1'b0;
		bus_i      = '0;
		repeat (5) @(posedge clk_i);
		#(DRIVE_DELAY);
		rst_n_i = 1'b1;
		check_reset();
		readback_regs();
		deliver_words();
		back_to_back();
		ramp_sequences();
		wilk_abort();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// ==== src.f ====
lab4_reg_pkg.sv
lab4_chip_pkg.sv
lab4_reg_bank.sv
lab4_serial_shifter.sv
lab4_ramp_sequencer.sv
lab4_controller.sv
tb_lab4_controller.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_lab4_controller
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
LINTFLAGS ?= --lint-only --timing --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
